// ==== Makefile ====
# Verilator build and run of the PBCH ibar_SSB detector testbench

TOP = tb_pbch_ibar_detector

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f

# the run passes only when the log holds the pass line
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== design/dmrs_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pbch_params.svh"

module dmrs_lane #(
    parameter int IBAR = 0
) (
    input  wire                        clk_i,
    input  wire                        reset_ni,
    input  wire pbch_pkg::seq_beat_t   seq_i,
    input  wire pbch_pkg::n_id_t       n_id_i,
    input  wire pbch_pkg::pilot_beat_t beat_i,
    output pbch_pkg::corr_t            corr_o,
    output pbch_pkg::corr_t            corr_rot_o,
    output logic                       done_o
);

    localparam int LFSR_W = `PBCH_LFSR_LEN;
    localparam int BIT_W = $clog2(2*`PBCH_PILOTS);
    localparam int IBAR_P1 = IBAR + 1;

    logic [LFSR_W-1:0] c_init;
    logic [LFSR_W-1:0] x2_q;
    pbch_pkg::pilot_t mem_q [`PBCH_PILOTS];
    pbch_pkg::pilot_t exp_pilot;
    pbch_pkg::corr_t corr_q;
    pbch_pkg::corr_t corr_rot_q;
    logic done_q;

    // +2 when both bits agree, -2 when both differ, 0 otherwise
    function automatic pbch_pkg::corr_t pilot_score(input pbch_pkg::pilot_t exp_p,
                                                    input pbch_pkg::pilot_t rx_p);
        pbch_pkg::corr_t score;
        case (exp_p ^ rx_p)
            2'b00: score = 9'sd2;
            2'b11: score = -9'sd2;
            default: score = 9'sd0;
        endcase
        return score;
    endfunction

    // c_init of the PBCH DMRS with ibar_SSB fixed per lane
    assign c_init = LFSR_W'(IBAR_P1 * (int'(n_id_i >> 2) + 1) * 2048
                            + IBAR_P1 * 64 + int'(n_id_i[1:0]));

    // x2(n+31) = x2(n+3) + x2(n+2) + x2(n+1) + x2(n)
    always_ff @(posedge clk_i) begin
        if (seq_i.load) begin
            x2_q <= c_init;
        end else if (seq_i.shift) begin
            x2_q <= {x2_q[3] ^ x2_q[2] ^ x2_q[1] ^ x2_q[0], x2_q[LFSR_W-1:1]};
        end
    end

    // even sequence bits give the real sign, odd bits the imaginary sign
    always_ff @(posedge clk_i) begin
        if (seq_i.store) begin
            if (!seq_i.bit_idx[0]) begin
                mem_q[seq_i.bit_idx[BIT_W-1:1]][1] <= seq_i.x1 ^ x2_q[0];
            end else begin
                mem_q[seq_i.bit_idx[BIT_W-1:1]][0] <= seq_i.x1 ^ x2_q[0];
            end
        end
    end

    assign exp_pilot = mem_q[beat_i.idx];

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            corr_q <= '0;
            corr_rot_q <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= beat_i.last;
            if (beat_i.valid) begin
                if (beat_i.first) begin
                    corr_q <= pilot_score(exp_pilot, beat_i.rx);
                    corr_rot_q <= pilot_score(exp_pilot, beat_i.rot);
                end else begin
                    corr_q <= corr_q + pilot_score(exp_pilot, beat_i.rx);
                    corr_rot_q <= corr_rot_q + pilot_score(exp_pilot, beat_i.rot);
                end
            end
        end
    end

    assign corr_o = corr_q;
    assign corr_rot_o = corr_rot_q;
    assign done_o = done_q;

endmodule

`default_nettype wire

// ==== design/dmrs_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pbch_params.svh"

module dmrs_sequencer (
    input  wire                    clk_i,
    input  wire                    reset_ni,
    input  wire pbch_pkg::n_id_t   n_id_i,
    input  wire                    n_id_valid_i,
    output pbch_pkg::seq_beat_t    seq_o,
    output pbch_pkg::n_id_t        n_id_o,
    output logic [1:0]             pilot_offset_o,
    output logic                   dmrs_ready_o
);

    localparam int LFSR_W = `PBCH_LFSR_LEN;
    localparam int CNT_W = $clog2(`PBCH_SKIP_LEN);
    localparam int BIT_W = $clog2(2*`PBCH_PILOTS);
    localparam logic [LFSR_W-1:0] X1_START = LFSR_W'(1);
    localparam logic [CNT_W-1:0] SKIP_LAST = CNT_W'(`PBCH_SKIP_LEN - 1);
    localparam logic [CNT_W-1:0] STORE_LAST = CNT_W'(2*`PBCH_PILOTS - 1);

    pbch_pkg::seq_state_e state_q;
    logic [CNT_W-1:0] cnt_q;
    pbch_pkg::n_id_t n_id_q;
    logic [LFSR_W-1:0] x1_q;

    // a new cell identity restarts generation from any state
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= pbch_pkg::IDLE;
            cnt_q <= '0;
            n_id_q <= '0;
        end else if (n_id_valid_i) begin
            state_q <= pbch_pkg::LOAD;
            cnt_q <= '0;
            n_id_q <= n_id_i;
        end else begin
            case (state_q)
                pbch_pkg::LOAD: begin
                    cnt_q <= '0;
                    state_q <= pbch_pkg::SKIP;
                end
                pbch_pkg::SKIP: begin
                    if (cnt_q == SKIP_LAST) begin
                        cnt_q <= '0;
                        state_q <= pbch_pkg::STORE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                pbch_pkg::STORE: begin
                    if (cnt_q == STORE_LAST) begin
                        state_q <= pbch_pkg::DONE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: state_q <= state_q;
            endcase
        end
    end

    // x1(n+31) = x1(n+3) + x1(n), bit 0 holds x1(n)
    always_ff @(posedge clk_i) begin
        if (seq_o.load) begin
            x1_q <= X1_START;
        end else if (seq_o.shift) begin
            x1_q <= {x1_q[3] ^ x1_q[0], x1_q[LFSR_W-1:1]};
        end
    end

    always_comb begin
        seq_o.x1 = x1_q[0];
        seq_o.load = (state_q == pbch_pkg::LOAD);
        seq_o.shift = (state_q == pbch_pkg::SKIP) || (state_q == pbch_pkg::STORE);
        seq_o.store = (state_q == pbch_pkg::STORE);
        seq_o.bit_idx = cnt_q[BIT_W-1:0];
    end

    assign n_id_o = n_id_q;
    assign pilot_offset_o = n_id_q[1:0];
    assign dmrs_ready_o = (state_q == pbch_pkg::DONE);

    // stored bits come as one unbroken run whose bit index counts up from zero
    store_run_in_order: assert property (@(posedge clk_i) disable iff (!reset_ni)
        seq_o.store |-> (seq_o.bit_idx == ($past(seq_o.store)
                                           ? BIT_W'($past(seq_o.bit_idx) + 1) : BIT_W'(0))))
        else $error("stored bit index out of order");

endmodule

`default_nettype wire

// ==== design/ibar_selector.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pbch_params.svh"

module ibar_selector (
    input  wire                  clk_i,
    input  wire                  reset_ni,
    input  wire pbch_pkg::corr_t corr_i [`PBCH_NUM_IBAR],
    input  wire pbch_pkg::corr_t corr_rot_i [`PBCH_NUM_IBAR],
    input  wire                  done_i,
    output pbch_pkg::ibar_t      ibar_o,
    output logic                 ibar_valid_o
);

    pbch_pkg::corr_mag_t lane_mag [`PBCH_NUM_IBAR];
    pbch_pkg::corr_mag_t best_mag;
    pbch_pkg::ibar_t best_idx;
    pbch_pkg::ibar_t ibar_q;
    logic valid_q;

    function automatic pbch_pkg::corr_mag_t magnitude(input pbch_pkg::corr_t c);
        return c[8] ? pbch_pkg::corr_mag_t'(-c) : pbch_pkg::corr_mag_t'(c);
    endfunction

    // a negated symbol still correlates, only with the opposite sign
    always_comb begin
        for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
            if (magnitude(corr_rot_i[i]) > magnitude(corr_i[i])) begin
                lane_mag[i] = magnitude(corr_rot_i[i]);
            end else begin
                lane_mag[i] = magnitude(corr_i[i]);
            end
        end
    end

    // strict comparison keeps the lowest index on a tie
    always_comb begin
        best_mag = '0;
        best_idx = '0;
        for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
            if (lane_mag[i] > best_mag) begin
                best_mag = lane_mag[i];
                best_idx = pbch_pkg::ibar_t'(i);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            ibar_q <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= done_i;
            if (done_i) begin
                ibar_q <= best_idx;
            end
        end
    end

    assign ibar_o = ibar_q;
    assign ibar_valid_o = valid_q;

endmodule

`default_nettype wire

// ==== design/pbch_ibar_detector.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pbch_params.svh"

module pbch_ibar_detector (
    input  wire                    clk_i,
    input  wire                    reset_ni,
    input  wire pbch_pkg::n_id_t   n_id_i,
    input  wire                    n_id_valid_i,
    input  wire pbch_pkg::sample_t sample_i,
    input  wire                    sample_valid_i,
    input  wire                    pbch_start_i,
    output logic                   dmrs_ready_o,
    output pbch_pkg::ibar_t        ibar_o,
    output logic                   ibar_valid_o
);

    pbch_pkg::seq_beat_t seq_beat;
    pbch_pkg::n_id_t lane_n_id;
    logic [1:0] pilot_offset;
    pbch_pkg::pilot_beat_t pilot_beat;
    pbch_pkg::corr_t lane_corr [`PBCH_NUM_IBAR];
    pbch_pkg::corr_t lane_corr_rot [`PBCH_NUM_IBAR];
    logic [`PBCH_NUM_IBAR-1:0] lane_done;

    dmrs_sequencer u_sequencer (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .n_id_i         (n_id_i),
        .n_id_valid_i   (n_id_valid_i),
        .seq_o          (seq_beat),
        .n_id_o         (lane_n_id),
        .pilot_offset_o (pilot_offset),
        .dmrs_ready_o   (dmrs_ready_o)
    );

    pilot_extractor u_extractor (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .pbch_start_i   (pbch_start_i),
        .dmrs_ready_i   (dmrs_ready_o),
        .pilot_offset_i (pilot_offset),
        .beat_o         (pilot_beat)
    );

    // one lane per ibar_SSB candidate
    for (genvar g = 0; g < `PBCH_NUM_IBAR; g++) begin : g_lane
        dmrs_lane #(
            .IBAR (g)
        ) u_lane (
            .clk_i      (clk_i),
            .reset_ni   (reset_ni),
            .seq_i      (seq_beat),
            .n_id_i     (lane_n_id),
            .beat_i     (pilot_beat),
            .corr_o     (lane_corr[g]),
            .corr_rot_o (lane_corr_rot[g]),
            .done_o     (lane_done[g])
        );
    end

    // all lanes see the same beats, so lane 0's done stands for every lane
    ibar_selector u_selector (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .corr_i       (lane_corr),
        .corr_rot_i   (lane_corr_rot),
        .done_i       (lane_done[0]),
        .ibar_o       (ibar_o),
        .ibar_valid_o (ibar_valid_o)
    );

endmodule

`default_nettype wire

// ==== design/pbch_params.svh ====
`ifndef PBCH_PARAMS_SVH
`define PBCH_PARAMS_SVH

// one complex sample, real part in the low half and imaginary part in the high half
`define PBCH_IN_DW 32

// subcarriers in one PBCH symbol
`define PBCH_FFT_LEN 256

// number of ibar_SSB candidates, one DMRS sequence each
`define PBCH_NUM_IBAR 8

// length of both Gold-sequence shift registers
`define PBCH_LFSR_LEN 31

// sequence bits thrown away before the first stored bit (Nc)
`define PBCH_SKIP_LEN 1600

// QPSK pilots kept per candidate, two sequence bits each
`define PBCH_PILOTS 64

// distance between neighbouring pilot subcarriers
`define PBCH_PILOT_SPACING 4

`endif

// ==== design/pbch_pkg.sv ====
`default_nettype none

`include "pbch_params.svh"

package pbch_pkg;

    typedef logic [`PBCH_IN_DW-1:0] sample_t;
    typedef logic [9:0] n_id_t;
    typedef logic [$clog2(`PBCH_NUM_IBAR)-1:0] ibar_t;

    // bit 1 is the sign of the real part, bit 0 the sign of the imaginary part
    typedef logic [1:0] pilot_t;
    typedef logic [$clog2(`PBCH_PILOTS)-1:0] pilot_idx_t;

    // a full match over 64 pilots sums to +128, so 9 signed bits are needed
    typedef logic signed [8:0] corr_t;
    typedef logic [8:0] corr_mag_t;

    typedef enum logic [2:0] {IDLE, LOAD, SKIP, STORE, DONE} seq_state_e;
    typedef enum logic [1:0] {WAIT, COLLECT, DECIDE} det_state_e;

    // control beat from the sequencer to every lane
    typedef struct packed {
        logic x1;
        logic load;
        logic shift;
        logic store;
        logic [$clog2(2*`PBCH_PILOTS)-1:0] bit_idx;
    } seq_beat_t;

    // one demodulated pilot from the extractor to every lane
    typedef struct packed {
        logic valid;
        pilot_t rx;
        pilot_t rot;
        pilot_idx_t idx;
        logic first;
        logic last;
    } pilot_beat_t;

endpackage

`default_nettype wire

// ==== design/pilot_extractor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pbch_params.svh"

module pilot_extractor (
    input  wire                    clk_i,
    input  wire                    reset_ni,
    input  wire pbch_pkg::sample_t sample_i,
    input  wire                    sample_valid_i,
    input  wire                    pbch_start_i,
    input  wire                    dmrs_ready_i,
    input  wire [1:0]              pilot_offset_i,
    output pbch_pkg::pilot_beat_t  beat_o
);

    localparam int SC_W = $clog2(`PBCH_FFT_LEN);
    localparam int PCNT_W = $clog2(`PBCH_PILOTS) + 1;
    localparam int SPACING_W = $clog2(`PBCH_PILOT_SPACING);
    localparam int HALF = `PBCH_IN_DW / 2;
    localparam logic [SC_W-1:0] SC_LAST = SC_W'(`PBCH_FFT_LEN - 1);

    pbch_pkg::det_state_e state_q;
    logic [SC_W-1:0] sc_cnt_q;
    logic [PCNT_W-1:0] pilot_cnt_q;
    pbch_pkg::sample_t sample_q;
    logic pilot_q;
    logic first_q;
    pbch_pkg::pilot_idx_t idx_q;

    logic start;
    logic take;
    logic is_pilot;
    logic [SC_W-1:0] sc_now;
    logic [PCNT_W-1:0] pcnt_now;

    // the sample that carries pbch_start_i is subcarrier 0 of the symbol
    assign start = (state_q == pbch_pkg::WAIT) && pbch_start_i && dmrs_ready_i && sample_valid_i;
    assign take = sample_valid_i && ((state_q == pbch_pkg::COLLECT) || start);
    assign sc_now = (state_q == pbch_pkg::COLLECT) ? sc_cnt_q : '0;
    assign pcnt_now = (state_q == pbch_pkg::COLLECT) ? pilot_cnt_q : '0;
    assign is_pilot = take && (sc_now[SPACING_W-1:0] == pilot_offset_i);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= pbch_pkg::WAIT;
            sc_cnt_q <= '0;
            pilot_cnt_q <= '0;
            pilot_q <= 1'b0;
            first_q <= 1'b0;
            idx_q <= '0;
        end else begin
            pilot_q <= is_pilot;
            first_q <= is_pilot && (pcnt_now == '0);
            if (is_pilot) begin
                idx_q <= pcnt_now[PCNT_W-2:0];
            end
            if (take) begin
                sc_cnt_q <= sc_now + 1'b1;
                pilot_cnt_q <= pcnt_now + PCNT_W'(is_pilot);
            end
            case (state_q)
                pbch_pkg::WAIT: begin
                    if (start) begin
                        state_q <= pbch_pkg::COLLECT;
                    end
                end
                pbch_pkg::COLLECT: begin
                    if (take && (sc_now == SC_LAST)) begin
                        state_q <= pbch_pkg::DECIDE;
                    end
                end
                default: state_q <= pbch_pkg::WAIT;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        sample_q <= sample_i;
    end

    // the rotated demodulation undoes a quarter turn of the received constellation
    always_comb begin
        beat_o.valid = pilot_q;
        beat_o.rx = {sample_q[HALF-1], sample_q[`PBCH_IN_DW-1]};
        beat_o.rot = {~sample_q[`PBCH_IN_DW-1], sample_q[HALF-1]};
        beat_o.idx = idx_q;
        beat_o.first = first_q;
        beat_o.last = (state_q == pbch_pkg::DECIDE);
    end

    pilot_idx_in_range: assert property (@(posedge clk_i) disable iff (!reset_ni)
        is_pilot |-> (pcnt_now < PCNT_W'(`PBCH_PILOTS)))
        else $error("pilot index beyond the pilot store");

    // a complete symbol has delivered every pilot exactly once
    all_pilots_seen: assert property (@(posedge clk_i) disable iff (!reset_ni)
        (state_q == pbch_pkg::DECIDE) |-> (pilot_cnt_q == PCNT_W'(`PBCH_PILOTS)))
        else $error("symbol ended with a wrong pilot count");

endmodule

`default_nettype wire

// ==== tb/dmrs_ref_model.svh ====
`ifndef DMRS_REF_MODEL_SVH
`define DMRS_REF_MODEL_SVH

// c_init of the PBCH DMRS for one ibar_SSB candidate and one cell identity
function automatic logic [`PBCH_LFSR_LEN-1:0] ref_c_init(input int ibar,
                                                         input pbch_pkg::n_id_t n_id);
    int value;
    value = 2048 * (ibar + 1) * (int'(n_id) / 4 + 1) + 64 * (ibar + 1) + int'(n_id) % 4;
    return value[`PBCH_LFSR_LEN-1:0];
endfunction

// c(0) to c(127) of the Gold sequence, taken after the first Nc bits are discarded
function automatic logic [2*`PBCH_PILOTS-1:0] ref_gold_bits(
        input logic [`PBCH_LFSR_LEN-1:0] c_init);
    logic x1 [`PBCH_SKIP_LEN + 2*`PBCH_PILOTS + `PBCH_LFSR_LEN];
    logic x2 [`PBCH_SKIP_LEN + 2*`PBCH_PILOTS + `PBCH_LFSR_LEN];
    logic [2*`PBCH_PILOTS-1:0] bits;
    for (int n = 0; n < `PBCH_LFSR_LEN; n++) begin
        x1[n] = (n == 0);
        x2[n] = c_init[n];
    end
    for (int n = 0; n < `PBCH_SKIP_LEN + 2*`PBCH_PILOTS; n++) begin
        x1[n + 31] = x1[n + 3] ^ x1[n];
        x2[n + 31] = x2[n + 3] ^ x2[n + 2] ^ x2[n + 1] ^ x2[n];
    end
    for (int n = 0; n < 2*`PBCH_PILOTS; n++) begin
        bits[n] = x1[n + `PBCH_SKIP_LEN] ^ x2[n + `PBCH_SKIP_LEN];
    end
    return bits;
endfunction

// pilot m takes c(2m) as its real sign and c(2m+1) as its imaginary sign
function automatic pbch_pkg::pilot_t ref_pilot(input logic [2*`PBCH_PILOTS-1:0] bits,
                                               input int m);
    return {bits[2*m], bits[2*m + 1]};
endfunction

// a set pilot bit gives a negative component of magnitude 1000
function automatic pbch_pkg::sample_t qpsk_sample(input pbch_pkg::pilot_t p);
    logic signed [15:0] re;
    logic signed [15:0] im;
    re = p[1] ? -16'sd1000 : 16'sd1000;
    im = p[0] ? -16'sd1000 : 16'sd1000;
    return {im, re};
endfunction

`endif

// ==== tb/tb_pbch_ibar_detector.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pbch_params.svh"

module tb_pbch_ibar_detector;

    localparam int READY_LATENCY = 1 + `PBCH_SKIP_LEN + 2*`PBCH_PILOTS;
    localparam int READY_TIMEOUT = 2 * READY_LATENCY;
    localparam int RESULT_TIMEOUT = 64;
    localparam int NUM_RESULTS = 4;
    localparam int NUM_CELL_IDS = 1008;
    localparam int MODE_PLAIN = 0;
    localparam int MODE_ROT = 1;
    localparam int MODE_NEG = 2;

    logic clk_i;
    logic reset_ni;
    pbch_pkg::n_id_t n_id_i;
    logic n_id_valid_i;
    pbch_pkg::sample_t sample_i;
    logic sample_valid_i;
    logic pbch_start_i;
    logic dmrs_ready_o;
    pbch_pkg::ibar_t ibar_o;
    logic ibar_valid_o;

    integer seed;
    int value_errors;
    int other_errors;
    int results_seen;
    int nid_age;
    logic last_sample;
    logic pending;
    pbch_pkg::ibar_t exp_ibar;
    pbch_pkg::n_id_t n_id_a;
    pbch_pkg::n_id_t n_id_b;
    pbch_pkg::ibar_t k_a;
    pbch_pkg::ibar_t k_b;

    `include "dmrs_ref_model.svh"

    pbch_ibar_detector UUT (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .n_id_i         (n_id_i),
        .n_id_valid_i   (n_id_valid_i),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .pbch_start_i   (pbch_start_i),
        .dmrs_ready_o   (dmrs_ready_o),
        .ibar_o         (ibar_o),
        .ibar_valid_o   (ibar_valid_o)
    );

    always #4 clk_i = ~clk_i;

    // clock edges since the last N_id strobe was taken
    always @(posedge clk_i) begin
        if (n_id_valid_i) begin
            nid_age <= 0;
        end else begin
            nid_age <= nid_age + 1;
        end
    end

    reset_values: assert property (@(posedge clk_i)
        $rose(reset_ni) |-> !dmrs_ready_o && !ibar_valid_o && (ibar_o == '0))
        else begin
            value_errors = value_errors + 1;
            $display("Fail at %0t: outputs not cleared by reset", $time);
        end

    ready_drops: assert property (@(posedge clk_i) disable iff (!reset_ni)
        n_id_valid_i |=> !dmrs_ready_o)
        else begin
            value_errors = value_errors + 1;
            $display("Fail at %0t: dmrs_ready_o stayed high after a new N_id", $time);
        end

    ready_latency: assert property (@(posedge clk_i) disable iff (!reset_ni)
        $rose(dmrs_ready_o) |-> (nid_age == READY_LATENCY))
        else begin
            value_errors = value_errors + 1;
            $display("Fail at %0t: dmrs_ready_o rose %0d cycles after N_id, expected %0d",
                     $time, $sampled(nid_age), READY_LATENCY);
        end

    pulse_expected: assert property (@(posedge clk_i) disable iff (!reset_ni)
        ibar_valid_o |-> pending)
        else begin
            value_errors = value_errors + 1;
            $display("Fail at %0t: ibar_valid_o pulsed without an accepted symbol", $time);
        end

    ibar_value: assert property (@(posedge clk_i) disable iff (!reset_ni)
        ibar_valid_o |-> (ibar_o == exp_ibar))
        else begin
            value_errors = value_errors + 1;
            $display("Fail at %0t: ibar_o is %0d, expected %0d",
                     $time, $sampled(ibar_o), $sampled(exp_ibar));
        end

    pulse_width: assert property (@(posedge clk_i) disable iff (!reset_ni)
        ibar_valid_o |=> !ibar_valid_o)
        else begin
            value_errors = value_errors + 1;
            $display("Fail at %0t: ibar_valid_o high for more than one cycle", $time);
        end

    // the pulse follows the 256th sample by the extractor, lane and selector registers
    pulse_timing: assert property (@(posedge clk_i) disable iff (!reset_ni)
        last_sample && pending |-> ##3 ibar_valid_o)
        else begin
            value_errors = value_errors + 1;
            $display("Fail at %0t: ibar_valid_o missing after the last sample", $time);
        end

    task automatic drive_n_id(input pbch_pkg::n_id_t value);
        @(posedge clk_i);
        n_id_i <= value;
        n_id_valid_i <= 1'b1;
        @(posedge clk_i);
        n_id_valid_i <= 1'b0;
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        while (!dmrs_ready_o && cycles < READY_TIMEOUT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!dmrs_ready_o) begin
            other_errors++;
            $display("dmrs_ready_o never rose after the new N_id (time %0t)", $time);
        end
    endtask

    // one symbol of candidate k, with an idle cycle now and then between samples
    task automatic send_symbol(input pbch_pkg::n_id_t n_id, input int k, input int mode,
                               input logic expect_result);
        logic [2*`PBCH_PILOTS-1:0] bits;
        logic signed [15:0] re;
        logic signed [15:0] im;
        pbch_pkg::sample_t s;
        int sc;
        bits = ref_gold_bits(ref_c_init(k, n_id));
        sc = 0;
        while (sc < `PBCH_FFT_LEN) begin
            @(posedge clk_i);
            if (sc > 0 && ($random(seed) & 7) == 0) begin
                sample_valid_i <= 1'b0;
                pbch_start_i <= 1'b0;
                last_sample <= 1'b0;
            end else begin
                if (sc % `PBCH_PILOT_SPACING == int'(n_id) % 4) begin
                    s = qpsk_sample(ref_pilot(bits, sc / `PBCH_PILOT_SPACING));
                end else begin
                    s = $random(seed);
                end
                re = s[15:0];
                im = s[31:16];
                // a quarter turn maps re + j*im to -im + j*re
                if (mode == MODE_ROT) begin
                    s = {re, -im};
                end else if (mode == MODE_NEG) begin
                    s = {-im, -re};
                end
                sample_i <= s;
                sample_valid_i <= 1'b1;
                pbch_start_i <= (sc == 0);
                last_sample <= (sc == `PBCH_FFT_LEN - 1);
                if (sc == 0 && expect_result) begin
                    pending <= 1'b1;
                    exp_ibar <= pbch_pkg::ibar_t'(k);
                end
                sc++;
            end
        end
        @(posedge clk_i);
        sample_valid_i <= 1'b0;
        pbch_start_i <= 1'b0;
        last_sample <= 1'b0;
    endtask

    task automatic wait_result();
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        while (!ibar_valid_o && cycles < RESULT_TIMEOUT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (ibar_valid_o) begin
            results_seen++;
        end else begin
            other_errors++;
            $display("no ibar_valid_o pulse after the PBCH symbol (time %0t)", $time);
        end
        @(posedge clk_i);
        pending <= 1'b0;
    endtask

    initial begin
        seed = 32'hd246d002;
        clk_i = 1'b0;
        reset_ni = 1'b0;
        n_id_i = '0;
        n_id_valid_i = 1'b0;
        sample_i = '0;
        sample_valid_i = 1'b0;
        pbch_start_i = 1'b0;
        last_sample = 1'b0;
        pending = 1'b0;
        exp_ibar = '0;
        nid_age = 0;
        value_errors = 0;
        other_errors = 0;
        results_seen = 0;
        repeat (10) @(posedge clk_i);
        reset_ni <= 1'b1;

        n_id_a = pbch_pkg::n_id_t'($unsigned($random(seed)) % NUM_CELL_IDS);
        k_a = pbch_pkg::ibar_t'($unsigned($random(seed)) % `PBCH_NUM_IBAR);
        drive_n_id(n_id_a);
        wait_ready();
        send_symbol(n_id_a, int'(k_a), MODE_PLAIN, 1'b1);
        wait_result();
        send_symbol(n_id_a, int'(k_a), MODE_ROT, 1'b1);
        wait_result();
        send_symbol(n_id_a, int'(k_a), MODE_NEG, 1'b1);
        wait_result();

        // second cell identity with another pilot offset
        n_id_b = pbch_pkg::n_id_t'($unsigned($random(seed)) % NUM_CELL_IDS);
        if (n_id_b[1:0] == n_id_a[1:0]) begin
            n_id_b = n_id_b ^ 10'd1;
        end
        k_b = pbch_pkg::ibar_t'($unsigned($random(seed)) % `PBCH_NUM_IBAR);
        drive_n_id(n_id_b);
        // sequences are still being generated, so this symbol must be dropped
        send_symbol(n_id_b, int'(k_b), MODE_PLAIN, 1'b0);
        repeat (8) @(posedge clk_i);
        wait_ready();
        send_symbol(n_id_b, int'(k_b), MODE_PLAIN, 1'b1);
        wait_result();
        repeat (4) @(posedge clk_i);

        if (results_seen != NUM_RESULTS) begin
            other_errors++;
            $display("saw %0d detection results instead of %0d", results_seen, NUM_RESULTS);
        end
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+design
+incdir+tb
design/pbch_pkg.sv
design/dmrs_sequencer.sv
design/pilot_extractor.sv
design/dmrs_lane.sv
design/ibar_selector.sv
design/pbch_ibar_detector.sv
tb/tb_pbch_ibar_detector.sv
